/* logic/raster_params.svh */
// Every FIFO log-depth must be at least 1, and the widths must agree with the fragment_pkg fields
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Attribute widths in bits

// Position holds x and y as two 16-bit halves
`define POS_WIDTH 32

`define DEPTH_WIDTH 16

// Color holds four 8-bit channels
`define COLOR_WIDTH 32

// Texture coordinate holds s and t as two 16-bit halves
`define TEXCOORD_WIDTH 32

// Log2 of each attribute FIFO depth
// The depths differ on purpose, so the streams fill at different rates
`define POS_FIFO_LOG 2
`define DEPTH_FIFO_LOG 3
`define COLOR_FIFO_LOG 3
`define TEXCOORD_FIFO_LOG 2

`endif

/* logic/fragment_pkg.sv */
// Field sizes come from raster_params.svh; fragment_t puts pos at bit 0 and texcoord at the top
`include "raster_params.svh"

package fragment_pkg;

    // Screen position in whole pixels, x in the upper half
    typedef struct packed {
        logic [`POS_WIDTH/2-1:0] x;
        logic [`POS_WIDTH/2-1:0] y;
    } screen_pos_t;

    // Depth is an unsigned fixed-point value
    typedef logic [`DEPTH_WIDTH-1:0] depth_t;

    // Color with one byte per channel, red in the top byte
    typedef struct packed {
        logic [`COLOR_WIDTH/4-1:0] r;
        logic [`COLOR_WIDTH/4-1:0] g;
        logic [`COLOR_WIDTH/4-1:0] b;
        logic [`COLOR_WIDTH/4-1:0] a;
    } rgba8_t;

    // Texture coordinate, s in the upper half
    typedef struct packed {
        logic [`TEXCOORD_WIDTH/2-1:0] s;
        logic [`TEXCOORD_WIDTH/2-1:0] t;
    } texcoord_t;

    // The joined fragment word, 112 bits wide
    // The field order matches the concatenation of the four FIFO heads,
    // so pos sits at the least significant end
    typedef struct packed {
        texcoord_t   texcoord;
        rgba8_t      color;
        depth_t      depth;
        screen_pos_t pos;
    } fragment_t;

endpackage

/* logic/stream_pkg.sv */
// The mask must be non-zero and may only change while every buffer in the path is empty
package stream_pkg;

    // Number of attribute streams joined into one fragment
    localparam int NUM_STREAMS = 4;

    // One enable bit per stream, indexed by stream_id_e
    typedef logic [NUM_STREAMS-1:0] stream_mask_t;

    // Stream names in mask bit order
    typedef enum logic [1:0] {
        STREAM_POS      = 2'd0,
        STREAM_DEPTH    = 2'd1,
        STREAM_COLOR    = 2'd2,
        STREAM_TEXCOORD = 2'd3
    } stream_id_e;

    // A disabled stream is not waited for and its field in the fragment is undefined.
    // Sources on disabled streams are expected to keep valid low.

    // All streams enabled, handy as a default
    localparam stream_mask_t ALL_STREAMS = '1;

endpackage

/* logic/fifo_if.sv */
// Carries no clock or reset; the FIFO takes those as plain ports
`timescale 1ns/100ps

interface fifo_if #(
    parameter int WIDTH = 8
);

    // Write side
    logic             wr;
    logic [WIDTH-1:0] wr_data;
    logic             full;

    // Read side, rd_data shows the head entry without a read
    logic             rd;
    logic [WIDTH-1:0] rd_data;
    logic             empty;

    // The writer of the FIFO
    modport producer (
        output wr,
        output wr_data,
        input  full
    );

    // The reader of the FIFO
    modport consumer (
        output rd,
        input  rd_data,
        input  empty
    );

    // The FIFO itself
    modport fifo (
        input  wr,
        input  wr_data,
        input  rd,
        output full,
        output rd_data,
        output empty
    );

endinterface

/* logic/sync_fifo.sv */
// LOG_DEPTH must be at least 1; writes when full and reads when empty are dropped silently
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH     = 8,
    parameter int LOG_DEPTH = 2
)
(
    input  logic  aclk,
    input  logic  i_reset,
    fifo_if.fifo  f
);

    localparam int DEPTH = 1 << LOG_DEPTH;

    // Storage has no reset, only the pointers do
    logic [WIDTH-1:0]   mem [DEPTH];

    // Pointers carry one extra bit so a full buffer differs from an empty one
    logic [LOG_DEPTH:0] wr_ptr;
    logic [LOG_DEPTH:0] rd_ptr;

    logic               do_write;
    logic               do_read;
    logic               ptr_wrapped;
    logic               addr_match;

    // Status flags come straight from the registered pointers
    assign addr_match  = (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]);
    assign ptr_wrapped = (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]);

    assign f.empty = addr_match && !ptr_wrapped;
    assign f.full  = addr_match && ptr_wrapped;

    assign do_write = f.wr && !f.full;
    assign do_read  = f.rd && !f.empty;

    // First word fall through, the head entry is always on rd_data
    assign f.rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];

    always_ff @(posedge aclk)
    begin
        if (do_write)
        begin
            mem[wr_ptr[LOG_DEPTH-1:0]] <= f.wr_data;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
        end
        else if (do_write)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // A read in the same cycle as a write is fine, since the
    // write lands in a slot other than the head
    always_ff @(posedge aclk)
    begin
        if (i_reset)
        begin
            rd_ptr <= '0;
        end
        else if (do_read)
        begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* logic/stream_concat_fifo.sv */
// o_valid and o_data are combinational from FIFO state; fields of disabled streams are undefined
`timescale 1ns/100ps
`include "raster_params.svh"

module stream_concat_fifo
    import fragment_pkg::*;
    import stream_pkg::*;
(
    input  logic         aclk,
    input  logic         i_reset,
    input  stream_mask_t i_stream_enable,

    input  logic         i_pos_valid,
    input  screen_pos_t  i_pos_data,
    output logic         o_pos_ready,

    input  logic         i_depth_valid,
    input  depth_t       i_depth_data,
    output logic         o_depth_ready,

    input  logic         i_color_valid,
    input  rgba8_t       i_color_data,
    output logic         o_color_ready,

    input  logic         i_texcoord_valid,
    input  texcoord_t    i_texcoord_data,
    output logic         o_texcoord_ready,

    output logic         o_valid,
    output fragment_t    o_data,
    input  logic         i_ready
);

    fifo_if #(.WIDTH(`POS_WIDTH))      pos_f ();
    fifo_if #(.WIDTH(`DEPTH_WIDTH))    depth_f ();
    fifo_if #(.WIDTH(`COLOR_WIDTH))    color_f ();
    fifo_if #(.WIDTH(`TEXCOORD_WIDTH)) texcoord_f ();

    stream_mask_t fifo_empty;
    logic         frag_available;
    logic         pop;

    // Input side, ready is simply the inverse of full
    assign pos_f.wr      = i_pos_valid;
    assign pos_f.wr_data = i_pos_data;
    assign o_pos_ready   = !pos_f.full;

    assign depth_f.wr      = i_depth_valid;
    assign depth_f.wr_data = i_depth_data;
    assign o_depth_ready   = !depth_f.full;

    assign color_f.wr      = i_color_valid;
    assign color_f.wr_data = i_color_data;
    assign o_color_ready   = !color_f.full;

    assign texcoord_f.wr      = i_texcoord_valid;
    assign texcoord_f.wr_data = i_texcoord_data;
    assign o_texcoord_ready   = !texcoord_f.full;

    // A fragment is complete when every enabled stream has a head entry
    assign fifo_empty = {texcoord_f.empty, color_f.empty, depth_f.empty, pos_f.empty};
    assign frag_available = &(~fifo_empty | ~i_stream_enable);
    assign pop = frag_available && i_ready;

    // All enabled FIFOs pop together, which keeps the streams aligned
    assign pos_f.rd      = pop && i_stream_enable[STREAM_POS];
    assign depth_f.rd    = pop && i_stream_enable[STREAM_DEPTH];
    assign color_f.rd    = pop && i_stream_enable[STREAM_COLOR];
    assign texcoord_f.rd = pop && i_stream_enable[STREAM_TEXCOORD];

    assign o_valid = frag_available;
    assign o_data  = {texcoord_f.rd_data, color_f.rd_data, depth_f.rd_data, pos_f.rd_data};

    sync_fifo #(.WIDTH(`POS_WIDTH), .LOG_DEPTH(`POS_FIFO_LOG)) u_pos_fifo (
        .aclk    (aclk),
        .i_reset (i_reset),
        .f       (pos_f)
    );

    sync_fifo #(.WIDTH(`DEPTH_WIDTH), .LOG_DEPTH(`DEPTH_FIFO_LOG)) u_depth_fifo (
        .aclk    (aclk),
        .i_reset (i_reset),
        .f       (depth_f)
    );

    sync_fifo #(.WIDTH(`COLOR_WIDTH), .LOG_DEPTH(`COLOR_FIFO_LOG)) u_color_fifo (
        .aclk    (aclk),
        .i_reset (i_reset),
        .f       (color_f)
    );

    sync_fifo #(.WIDTH(`TEXCOORD_WIDTH), .LOG_DEPTH(`TEXCOORD_FIFO_LOG)) u_texcoord_fifo (
        .aclk    (aclk),
        .i_reset (i_reset),
        .f       (texcoord_f)
    );

endmodule

/* logic/frag_skid_buffer.sv */
// Two entries deep; o_valid and o_ready come from registers, so a word takes one cycle through
`timescale 1ns/100ps

module frag_skid_buffer
    import fragment_pkg::*;
(
    input  logic      aclk,
    input  logic      i_reset,

    input  logic      i_valid,
    input  fragment_t i_data,
    output logic      o_ready,

    output logic      o_valid,
    output fragment_t o_data,
    input  logic      i_ready
);

    logic      main_valid;
    logic      spare_valid;
    fragment_t main_data;
    fragment_t spare_data;

    logic      accept;
    logic      main_free;

    // Upstream may send while the spare entry is free
    assign o_ready = !spare_valid;
    assign accept  = i_valid && !spare_valid;

    // The main entry can take a new word when it is empty or being drained
    assign main_free = !main_valid || i_ready;

    assign o_valid = main_valid;
    assign o_data  = main_data;

    always_ff @(posedge aclk)
    begin
        if (i_reset)
        begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end
        else if (main_free)
        begin
            // The spare holds the older word, so it goes first
            main_valid  <= spare_valid || accept;
            spare_valid <= 1'b0;
        end
        else if (accept)
        begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (main_free)
        begin
            main_data <= spare_valid ? spare_data : i_data;
        end
        if (!main_free && accept)
        begin
            spare_data <= i_data;
        end
    end

endmodule

/* logic/fragment_stream_top.sv */
// The enable mask must be non-zero and may change only when the FIFOs and the output slice are empty
`timescale 1ns/100ps

module fragment_stream_top
    import fragment_pkg::*;
    import stream_pkg::*;
(
    input  logic         aclk,
    input  logic         i_reset,
    input  stream_mask_t i_stream_enable,

    input  logic         i_pos_valid,
    input  screen_pos_t  i_pos_data,
    output logic         o_pos_ready,

    input  logic         i_depth_valid,
    input  depth_t       i_depth_data,
    output logic         o_depth_ready,

    input  logic         i_color_valid,
    input  rgba8_t       i_color_data,
    output logic         o_color_ready,

    input  logic         i_texcoord_valid,
    input  texcoord_t    i_texcoord_data,
    output logic         o_texcoord_ready,

    output logic         o_frag_valid,
    output fragment_t    o_frag_data,
    input  logic         i_frag_ready
);

    // Joined fragment between the FIFOs and the output slice
    logic      joined_valid;
    fragment_t joined_data;
    logic      joined_ready;

    stream_concat_fifo u_concat (
        .aclk             (aclk),
        .i_reset          (i_reset),
        .i_stream_enable  (i_stream_enable),
        .i_pos_valid      (i_pos_valid),
        .i_pos_data       (i_pos_data),
        .o_pos_ready      (o_pos_ready),
        .i_depth_valid    (i_depth_valid),
        .i_depth_data     (i_depth_data),
        .o_depth_ready    (o_depth_ready),
        .i_color_valid    (i_color_valid),
        .i_color_data     (i_color_data),
        .o_color_ready    (o_color_ready),
        .i_texcoord_valid (i_texcoord_valid),
        .i_texcoord_data  (i_texcoord_data),
        .o_texcoord_ready (o_texcoord_ready),
        .o_valid          (joined_valid),
        .o_data           (joined_data),
        .i_ready          (joined_ready)
    );

    // The slice breaks the combinational valid of the joiner
    frag_skid_buffer u_skid (
        .aclk    (aclk),
        .i_reset (i_reset),
        .i_valid (joined_valid),
        .i_data  (joined_data),
        .o_ready (joined_ready),
        .o_valid (o_frag_valid),
        .o_data  (o_frag_data),
        .i_ready (i_frag_ready)
    );

endmodule

/* testbench/fragment_stream_sva.sv */
// Bound to fragment_stream_top; every check but the post-reset one is off while i_reset is high
`timescale 1ns/100ps

module fragment_stream_sva
    import fragment_pkg::*;
    import stream_pkg::*;
(
    input logic         aclk,
    input logic         i_reset,
    input stream_mask_t i_stream_enable,
    input logic         o_pos_ready,
    input logic         o_depth_ready,
    input logic         o_color_ready,
    input logic         o_texcoord_ready,
    input logic         o_frag_valid,
    input fragment_t    o_frag_data,
    input logic         i_frag_ready
);

    mask_nonzero: assert property (@(posedge aclk) disable iff (i_reset)
        i_stream_enable != '0)
        else $error("stream enable mask is zero");

    // An offered fragment stays offered until the sink takes it
    valid_held: assert property (@(posedge aclk) disable iff (i_reset)
        o_frag_valid && !i_frag_ready |=> o_frag_valid)
        else $error("o_frag_valid dropped during a stall");

    data_held: assert property (@(posedge aclk) disable iff (i_reset)
        o_frag_valid && !i_frag_ready |=> $stable(o_frag_data))
        else $error("o_frag_data changed during a stall");

    // Every FIFO is empty right after reset, so no input can be refused
    ready_after_reset: assert property (@(posedge aclk)
        $fell(i_reset) |-> o_pos_ready && o_depth_ready && o_color_ready && o_texcoord_ready)
        else $error("an input ready is low in the cycle after reset");

endmodule

bind fragment_stream_top fragment_stream_sva u_sva (
    .aclk             (aclk),
    .i_reset          (i_reset),
    .i_stream_enable  (i_stream_enable),
    .o_pos_ready      (o_pos_ready),
    .o_depth_ready    (o_depth_ready),
    .o_color_ready    (o_color_ready),
    .o_texcoord_ready (o_texcoord_ready),
    .o_frag_valid     (o_frag_valid),
    .o_frag_data      (o_frag_data),
    .i_frag_ready     (i_frag_ready)
);

/* testbench/tb_fragment_stream.sv */
// Stimulus comes from a fixed-seed LFSR, and the first mismatch or a timeout ends the run
`timescale 1ns/100ps

module tb_fragment_stream
    import fragment_pkg::*;
    import stream_pkg::*;
();

    localparam int N_RANDOM       = 200;
    localparam int N_STALL        = 150;
    localparam int N_SUBSET       = 80;
    localparam int N_SKEW         = 60;
    localparam int N_TOTAL        = N_RANDOM + N_STALL + 2 * N_SUBSET + N_SKEW;
    localparam int TIMEOUT_CYCLES = 8 * N_TOTAL + 200;

    logic         aclk;
    logic         i_reset;
    stream_mask_t mask;
    logic         in_valid [4];
    logic [31:0]  in_data [4];
    logic [3:0]   in_ready;
    logic         i_frag_ready;
    logic         o_frag_valid;
    fragment_t    o_frag_data;

    // Expected words per stream are indexed like the enable mask
    logic [31:0]  exp_q [4][$];
    logic [31:0]  got [4];
    logic [31:0]  expected_word;
    string        field_name [4] = '{"o_frag_data.pos", "o_frag_data.depth",
                                     "o_frag_data.color", "o_frag_data.texcoord"};
    logic [31:0]  lfsr_state = 32'h79b3;
    int           frag_target = 0;
    int           frag_rx = 0;
    int           cycle_count = 0;
    int           ready_low_cycles = 0;
    logic         stall_prev = 1'b0;
    fragment_t    held_data;

    fragment_stream_top UUT (
        .aclk(aclk), .i_reset(i_reset), .i_stream_enable(mask),
        .i_pos_valid(in_valid[0]), .i_pos_data(in_data[0]), .o_pos_ready(in_ready[0]),
        .i_depth_valid(in_valid[1]), .i_depth_data(in_data[1][15:0]),
        .o_depth_ready(in_ready[1]),
        .i_color_valid(in_valid[2]), .i_color_data(in_data[2]), .o_color_ready(in_ready[2]),
        .i_texcoord_valid(in_valid[3]), .i_texcoord_data(in_data[3]),
        .o_texcoord_ready(in_ready[3]),
        .o_frag_valid(o_frag_valid), .o_frag_data(o_frag_data), .i_frag_ready(i_frag_ready)
    );

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Galois LFSR that steps once for each bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return bits;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [111:0] expected,
                               input logic [111:0] actual);
        if (actual !== expected)
            fail_run($sformatf("FAIL %s expected %0h actual %0h", name, expected, actual));
    endtask

    // Offers n words on every enabled stream with vld and rdy as chances out of 16
    task automatic run_phase(input stream_mask_t m, input int n, input int vld, input int rdy,
                             input int lead);
        int   remaining [4];
        logic taken [4];
        logic busy;
        int   cyc;
        mask = m;
        frag_target += n;
        for (int s = 0; s < 4; s++)
        begin
            remaining[s] = m[s] ? n : 0;
            taken[s] = 1'b0;
        end
        cyc = 0;
        busy = 1'b1;
        while (busy)
        begin
            @(negedge aclk);
            for (int s = 0; s < 4; s++)
            begin
                if (taken[s])
                begin
                    in_valid[s] = 1'b0;
                    taken[s] = 1'b0;
                end
                // During the lead only the position stream runs and it has no gaps
                if (!in_valid[s] && remaining[s] > 0 && (s == 0 || cyc >= lead)
                    && (cyc < lead || take_bits(4) < vld))
                begin
                    in_valid[s] = 1'b1;
                    in_data[s] = take_bits(s == int'(STREAM_DEPTH) ? 16 : 32);
                    remaining[s]--;
                end
            end
            i_frag_ready = (take_bits(4) < rdy);
            @(posedge aclk);
            if ((~in_ready & m) != '0)
                ready_low_cycles++;
            busy = 1'b0;
            for (int s = 0; s < 4; s++)
            begin
                if (in_valid[s] && in_ready[s])
                begin
                    exp_q[s].push_back(in_data[s]);
                    taken[s] = 1'b1;
                end
                if (remaining[s] > 0 || (in_valid[s] && !taken[s]))
                    busy = 1'b1;
            end
            cyc++;
        end
    endtask

    task automatic drain_output();
        @(negedge aclk);
        for (int s = 0; s < 4; s++)
            in_valid[s] = 1'b0;
        i_frag_ready = 1'b1;
        while (frag_rx < frag_target)
            @(negedge aclk);
    endtask

    always @(posedge aclk)
    begin
        if (!i_reset)
        begin
            if (stall_prev)
                check_value("o_frag_data", held_data, o_frag_data);
            if (o_frag_valid && i_frag_ready)
            begin
                got[0] = o_frag_data.pos;
                got[1] = {16'h0, o_frag_data.depth};
                got[2] = o_frag_data.color;
                got[3] = o_frag_data.texcoord;
                for (int s = 0; s < 4; s++)
                begin
                    if (mask[s] && exp_q[s].size() == 0)
                        fail_run($sformatf("%s came out with no input word sent", field_name[s]));
                    else if (mask[s])
                    begin
                        expected_word = exp_q[s].pop_front();
                        check_value(field_name[s], 112'(expected_word), 112'(got[s]));
                    end
                end
                frag_rx++;
            end
            stall_prev = o_frag_valid && !i_frag_ready;
            held_data = o_frag_data;
        end
    end

    always @(posedge aclk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            fail_run($sformatf("Timeout: run not finished after %0d cycles", TIMEOUT_CYCLES));
    end

    initial
    begin
        i_reset = 1'b1;
        mask = ALL_STREAMS;
        i_frag_ready = 1'b0;
        for (int s = 0; s < 4; s++)
        begin
            in_valid[s] = 1'b0;
            in_data[s] = '0;
        end
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        i_reset = 1'b0;
        check_value("o_frag_valid", 112'(1'b0), 112'(o_frag_valid));
        check_value("in_ready", 112'(4'hf), 112'(in_ready));

        run_phase(ALL_STREAMS, N_RANDOM, 8, 12, 0);
        drain_output();

        // Heavy back-pressure with sources always offering
        ready_low_cycles = 0;
        run_phase(ALL_STREAMS, N_STALL, 16, 3, 0);
        drain_output();
        if (ready_low_cycles == 0)
            fail_run("Input readies never fell while the output was stalled");

        run_phase(4'b0101, N_SUBSET, 10, 10, 0);
        drain_output();
        run_phase(4'b0010, N_SUBSET, 10, 10, 0);
        drain_output();

        // Position runs ahead until its FIFO is full
        run_phase(ALL_STREAMS, N_SKEW, 8, 12, 12);
        drain_output();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+logic
logic/fragment_pkg.sv
logic/stream_pkg.sv
logic/fifo_if.sv
logic/sync_fifo.sv
logic/stream_concat_fifo.sv
logic/frag_skid_buffer.sv
logic/fragment_stream_top.sv
testbench/fragment_stream_sva.sv
testbench/tb_fragment_stream.sv

/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/Vtb_fragment_stream: compile.f $(wildcard logic/*.sv logic/*.svh testbench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f --top-module tb_fragment_stream -Mdir obj_dir

run: obj_dir/Vtb_fragment_stream
	@out="$$(./obj_dir/Vtb_fragment_stream)"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -f compile.f --top-module tb_fragment_stream

clean:
	rm -rf obj_dir
